// File: common/dodge_cfg_pkg.sv
`default_nettype none

package dodge_cfg_pkg;

	// Playfield
	localparam int GRID_CELLS = 5;
	localparam int NUM_BLOCKS = 10;

	// Cell placement on the 160x120 screen
	localparam int CELL_PITCH = 21;
	localparam int SQUARE_SIZE = 20;
	localparam int ORIGIN_X = 27;
	localparam int ORIGIN_Y = 7;

	// Idle cycles between game steps
	localparam int STEP_CYCLES = 64;

	localparam logic [15:0] LFSR_SEED = 16'h5a3c;

	// Edge and centre indices of the grid
	localparam logic [2:0] CELL_LAST = 3'(GRID_CELLS - 1);
	localparam logic [2:0] CELL_CENTRE = 3'((GRID_CELLS - 1) / 2);

	typedef struct packed {
		logic [2:0] col;
		logic [2:0] row;
	} cell_t;

	// Travel direction, up means towards row 0
	typedef enum logic [1:0] {
		DIR_DOWN,
		DIR_LEFT,
		DIR_UP,
		DIR_RIGHT
	} dir_t;

endpackage

`default_nettype wire

// File: common/dodge_bus_pkg.sv
`default_nettype none

package dodge_bus_pkg;

	// Pixel address is {row, column}
	localparam int PIX_X_W = 8;
	localparam int PIX_Y_W = 7;
	localparam int PIX_ADDR_W = PIX_Y_W + PIX_X_W;

	localparam int AXI_DATA_W = 32;
	localparam int RESP_W = 2;

	localparam int COLOUR_W = 3;
	localparam logic [COLOUR_W-1:0] COLOUR_BLOCK = 3'b100;
	localparam logic [COLOUR_W-1:0] COLOUR_PLAYER = 3'b010;
	localparam logic [COLOUR_W-1:0] COLOUR_ERASE = 3'b000;

	localparam logic [RESP_W-1:0] RESP_OKAY = 2'b00;

endpackage

`default_nettype wire

// File: game/game_control.sv
`timescale 1ns/1ps
`default_nettype none

module game_control (
	input logic clock,
	input logic reset,
	input logic start,
	input logic hit,
	input logic block_done,
	input logic player_done,
	output logic advance,
	output logic game_over,
	output logic block_paint_start,
	output logic player_paint_start,
	output logic [dodge_bus_pkg::COLOUR_W-1:0] paint_colour_block,
	output logic [dodge_bus_pkg::COLOUR_W-1:0] paint_colour_player
);

	enum logic [3:0] {
		IDLE,
		WAIT,
		ERASE_BLOCKS,
		ERASE_PLAYER,
		ADVANCE,
		CHECK,
		DRAW_BLOCKS,
		DRAW_PLAYER,
		OVER
	} state;

	logic [$clog2(dodge_cfg_pkg::STEP_CYCLES)-1:0] step_cnt;

	always_ff @(posedge clock)
	begin
		if (!reset)
		begin
			state <= IDLE;
			step_cnt <= '0;
			advance <= 1'b0;
			game_over <= 1'b0;
			block_paint_start <= 1'b0;
			player_paint_start <= 1'b0;
			paint_colour_block <= dodge_bus_pkg::COLOUR_ERASE;
			paint_colour_player <= dodge_bus_pkg::COLOUR_ERASE;
		end
		else
		begin
			advance <= 1'b0;
			block_paint_start <= 1'b0;
			player_paint_start <= 1'b0;
			// Painters are idle in these states, so a restart is safe
			if (start && (state == IDLE || state == WAIT || state == OVER))
			begin
				state <= WAIT;
				step_cnt <= '0;
				game_over <= 1'b0;
			end
			else
			begin
				case (state)
					WAIT:
					begin
						if (int'(step_cnt) == dodge_cfg_pkg::STEP_CYCLES - 1)
						begin
							state <= ERASE_BLOCKS;
							block_paint_start <= 1'b1;
							paint_colour_block <= dodge_bus_pkg::COLOUR_ERASE;
						end
						else
							step_cnt <= step_cnt + 1'b1;
					end
					ERASE_BLOCKS:
					begin
						if (block_done)
						begin
							state <= ERASE_PLAYER;
							player_paint_start <= 1'b1;
							paint_colour_player <= dodge_bus_pkg::COLOUR_ERASE;
						end
					end
					ERASE_PLAYER:
					begin
						if (player_done)
						begin
							state <= ADVANCE;
							advance <= 1'b1;
						end
					end
					ADVANCE:
					begin
						state <= CHECK;
						step_cnt <= '0;
					end
					CHECK:
					begin
						// hit settles two cycles after the advance pulse
						if (step_cnt == 1)
						begin
							if (hit)
							begin
								state <= OVER;
								game_over <= 1'b1;
							end
							else
							begin
								state <= DRAW_BLOCKS;
								block_paint_start <= 1'b1;
								paint_colour_block <= dodge_bus_pkg::COLOUR_BLOCK;
							end
						end
						else
							step_cnt <= step_cnt + 1'b1;
					end
					DRAW_BLOCKS:
					begin
						if (block_done)
						begin
							state <= DRAW_PLAYER;
							player_paint_start <= 1'b1;
							paint_colour_player <= dodge_bus_pkg::COLOUR_PLAYER;
						end
					end
					DRAW_PLAYER:
					begin
						if (player_done)
						begin
							state <= WAIT;
							step_cnt <= '0;
						end
					end
					default:
						state <= state;
				endcase
			end
		end
	end

	advance_in_state: assert property (
		@(posedge clock) disable iff (!reset) advance |-> state == ADVANCE);

endmodule

`default_nettype wire

// File: game/block_field.sv
`timescale 1ns/1ps
`default_nettype none

module block_field (
	input logic clock,
	input logic reset,
	input logic start,
	input logic advance,
	input dodge_cfg_pkg::cell_t player,
	output logic [dodge_cfg_pkg::NUM_BLOCKS-1:0] live,
	output dodge_cfg_pkg::cell_t [dodge_cfg_pkg::NUM_BLOCKS-1:0] cells,
	output logic hit
);

	dodge_cfg_pkg::dir_t [dodge_cfg_pkg::NUM_BLOCKS-1:0] dirs;
	dodge_cfg_pkg::dir_t [dodge_cfg_pkg::NUM_BLOCKS-1:0] next_dirs;
	dodge_cfg_pkg::cell_t [dodge_cfg_pkg::NUM_BLOCKS-1:0] next_cells;
	logic [dodge_cfg_pkg::NUM_BLOCKS-1:0] next_live;
	logic [dodge_cfg_pkg::NUM_BLOCKS-1:0] match;
	logic [3:0] slot;
	logic [15:0] lfsr;
	logic [2:0] lane;
	dodge_cfg_pkg::dir_t spawn_dir;
	dodge_cfg_pkg::cell_t spawn_cell;

	// Lane folded into 0..4, edge is opposite to the travel direction
	assign lane = (lfsr[4:2] > dodge_cfg_pkg::CELL_LAST) ?
		lfsr[4:2] - 3'(dodge_cfg_pkg::GRID_CELLS) : lfsr[4:2];
	assign spawn_dir = dodge_cfg_pkg::dir_t'(lfsr[1:0]);

	always_comb
	begin
		case (spawn_dir)
			dodge_cfg_pkg::DIR_DOWN: spawn_cell = '{col: lane, row: 3'd0};
			dodge_cfg_pkg::DIR_LEFT: spawn_cell = '{col: dodge_cfg_pkg::CELL_LAST, row: lane};
			dodge_cfg_pkg::DIR_UP: spawn_cell = '{col: lane, row: dodge_cfg_pkg::CELL_LAST};
			default: spawn_cell = '{col: 3'd0, row: lane};
		endcase
	end

	always_comb
	begin
		next_live = live;
		next_cells = cells;
		next_dirs = dirs;
		for (int i = 0; i < dodge_cfg_pkg::NUM_BLOCKS; i++)
		begin
			if (i == int'(slot))
			begin
				next_live[i] = 1'b1;
				next_cells[i] = spawn_cell;
				next_dirs[i] = spawn_dir;
			end
			else if (live[i])
			begin
				case (dirs[i])
					dodge_cfg_pkg::DIR_DOWN:
						if (cells[i].row == dodge_cfg_pkg::CELL_LAST)
							next_live[i] = 1'b0;
						else
							next_cells[i].row = cells[i].row + 3'd1;
					dodge_cfg_pkg::DIR_LEFT:
						if (cells[i].col == 3'd0)
							next_live[i] = 1'b0;
						else
							next_cells[i].col = cells[i].col - 3'd1;
					dodge_cfg_pkg::DIR_UP:
						if (cells[i].row == 3'd0)
							next_live[i] = 1'b0;
						else
							next_cells[i].row = cells[i].row - 3'd1;
					default:
						if (cells[i].col == dodge_cfg_pkg::CELL_LAST)
							next_live[i] = 1'b0;
						else
							next_cells[i].col = cells[i].col + 3'd1;
				endcase
			end
		end
	end

	always_comb
	begin
		for (int i = 0; i < dodge_cfg_pkg::NUM_BLOCKS; i++)
			match[i] = live[i] && (cells[i] == player);
	end

	always_ff @(posedge clock)
	begin
		if (!reset)
		begin
			live <= '0;
			slot <= '0;
			hit <= 1'b0;
			lfsr <= dodge_cfg_pkg::LFSR_SEED;
		end
		else
		begin
			// Taps 16, 14, 13, 11
			lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
			if (start)
			begin
				live <= '0;
				slot <= '0;
				hit <= 1'b0;
			end
			else
			begin
				hit <= |match;
				if (advance)
				begin
					live <= next_live;
					if (int'(slot) == dodge_cfg_pkg::NUM_BLOCKS - 1)
						slot <= '0;
					else
						slot <= slot + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (advance)
		begin
			cells <= next_cells;
			dirs <= next_dirs;
		end
	end

	for (genvar i = 0; i < dodge_cfg_pkg::NUM_BLOCKS; i++)
	begin : g_cell_check
		live_cell_on_grid: assert property (
			@(posedge clock) disable iff (!reset)
			live[i] |-> cells[i].col <= dodge_cfg_pkg::CELL_LAST &&
				cells[i].row <= dodge_cfg_pkg::CELL_LAST);
	end

endmodule

`default_nettype wire

// File: game/player_pos.sv
`timescale 1ns/1ps
`default_nettype none

module player_pos (
	input logic clock,
	input logic reset,
	input logic start,
	input logic advance,
	input logic move_left,
	input logic move_right,
	input logic move_up,
	input logic move_down,
	output dodge_cfg_pkg::cell_t player
);

	logic move_pending;
	dodge_cfg_pkg::dir_t move_dir;

	always_ff @(posedge clock)
	begin
		if (!reset || start)
		begin
			player <= '{col: dodge_cfg_pkg::CELL_CENTRE, row: dodge_cfg_pkg::CELL_CENTRE};
			move_pending <= 1'b0;
			move_dir <= dodge_cfg_pkg::DIR_DOWN;
		end
		else
		begin
			if (advance && move_pending)
			begin
				move_pending <= 1'b0;
				// Clamp at the grid edge
				case (move_dir)
					dodge_cfg_pkg::DIR_DOWN:
						if (player.row != dodge_cfg_pkg::CELL_LAST)
							player.row <= player.row + 3'd1;
					dodge_cfg_pkg::DIR_LEFT:
						if (player.col != 3'd0)
							player.col <= player.col - 3'd1;
					dodge_cfg_pkg::DIR_UP:
						if (player.row != 3'd0)
							player.row <= player.row - 3'd1;
					default:
						if (player.col != dodge_cfg_pkg::CELL_LAST)
							player.col <= player.col + 3'd1;
				endcase
			end
			// A pulse in the advance cycle is kept for the next step
			if (move_left || move_right || move_up || move_down)
			begin
				move_pending <= 1'b1;
				if (move_left)
					move_dir <= dodge_cfg_pkg::DIR_LEFT;
				else if (move_right)
					move_dir <= dodge_cfg_pkg::DIR_RIGHT;
				else if (move_up)
					move_dir <= dodge_cfg_pkg::DIR_UP;
				else
					move_dir <= dodge_cfg_pkg::DIR_DOWN;
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/square_painter.sv
`timescale 1ns/1ps
`default_nettype none

module square_painter #(
	parameter int SLOTS = 1
) (
	input logic clock,
	input logic reset,
	input logic paint_start,
	input logic [dodge_bus_pkg::COLOUR_W-1:0] paint_colour,
	input dodge_cfg_pkg::cell_t [SLOTS-1:0] cells,
	input logic [SLOTS-1:0] live,
	input logic grant,
	input logic pix_ack,
	output logic req,
	output logic paint_done,
	output logic [dodge_bus_pkg::PIX_ADDR_W-1:0] pix_addr,
	output logic [dodge_bus_pkg::COLOUR_W-1:0] pix_colour
);

	logic busy;
	logic gap;
	logic [$clog2(SLOTS+1)-1:0] slot;
	logic [$clog2(dodge_cfg_pkg::SQUARE_SIZE)-1:0] xcnt;
	logic [$clog2(dodge_cfg_pkg::SQUARE_SIZE)-1:0] ycnt;
	logic [dodge_bus_pkg::PIX_X_W-1:0] px;
	logic [dodge_bus_pkg::PIX_Y_W-1:0] py;
	logic pix_step;
	logic last_x;
	logic last_pix;

	assign pix_step = grant && pix_ack;
	assign last_x = int'(xcnt) == dodge_cfg_pkg::SQUARE_SIZE - 1;
	assign last_pix = last_x && int'(ycnt) == dodge_cfg_pkg::SQUARE_SIZE - 1;

	// One idle cycle after each square lets the arbiter hand over
	assign req = busy && !gap && live[slot];

	assign px = dodge_bus_pkg::PIX_X_W'(dodge_cfg_pkg::ORIGIN_X +
		int'(cells[slot].col) * dodge_cfg_pkg::CELL_PITCH + int'(xcnt));
	assign py = dodge_bus_pkg::PIX_Y_W'(dodge_cfg_pkg::ORIGIN_Y +
		int'(cells[slot].row) * dodge_cfg_pkg::CELL_PITCH + int'(ycnt));
	assign pix_addr = {py, px};

	always_ff @(posedge clock)
	begin
		if (!reset)
		begin
			busy <= 1'b0;
			gap <= 1'b0;
			slot <= '0;
			xcnt <= '0;
			ycnt <= '0;
			paint_done <= 1'b0;
		end
		else
		begin
			paint_done <= 1'b0;
			gap <= 1'b0;
			if (!busy)
			begin
				if (paint_start)
				begin
					busy <= 1'b1;
					slot <= '0;
					xcnt <= '0;
					ycnt <= '0;
				end
			end
			else if (!gap)
			begin
				// Dead slot or finished square
				if (!live[slot] || (pix_step && last_pix))
				begin
					xcnt <= '0;
					ycnt <= '0;
					if (int'(slot) == SLOTS - 1)
					begin
						busy <= 1'b0;
						paint_done <= 1'b1;
					end
					else
					begin
						slot <= slot + 1'b1;
						gap <= live[slot];
					end
				end
				else if (pix_step)
				begin
					if (last_x)
					begin
						xcnt <= '0;
						ycnt <= ycnt + 1'b1;
					end
					else
						xcnt <= xcnt + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (paint_start && !busy)
			pix_colour <= paint_colour;
	end

endmodule

`default_nettype wire

// File: logic/pixel_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_arbiter (
	input logic clock,
	input logic reset,
	input logic block_req,
	input logic [dodge_bus_pkg::PIX_ADDR_W-1:0] block_pix_addr,
	input logic [dodge_bus_pkg::COLOUR_W-1:0] block_pix_colour,
	input logic player_req,
	input logic [dodge_bus_pkg::PIX_ADDR_W-1:0] player_pix_addr,
	input logic [dodge_bus_pkg::COLOUR_W-1:0] player_pix_colour,
	output logic block_grant,
	output logic block_pix_ack,
	output logic player_grant,
	output logic player_pix_ack,
	output logic [dodge_bus_pkg::PIX_ADDR_W-1:0] awaddr,
	output logic awvalid,
	input logic awready,
	output logic [dodge_bus_pkg::AXI_DATA_W-1:0] wdata,
	output logic wvalid,
	input logic wready,
	input logic [dodge_bus_pkg::RESP_W-1:0] bresp,
	input logic bvalid,
	output logic bready
);

	enum logic [1:0] {
		W_IDLE,
		W_SEND,
		W_RESP
	} wstate;

	logic owner_req;
	logic start_write;
	logic pix_done;

	assign owner_req = (block_grant && block_req) || (player_grant && player_req);
	assign start_write = (wstate == W_IDLE) && owner_req;
	assign pix_done = bready && bvalid;
	assign block_pix_ack = block_grant && pix_done;
	assign player_pix_ack = player_grant && pix_done;

	// Grant changes only between writes, player wins ties
	always_ff @(posedge clock)
	begin
		if (!reset)
		begin
			block_grant <= 1'b0;
			player_grant <= 1'b0;
		end
		else if (wstate == W_IDLE && !owner_req)
		begin
			if (block_grant || player_grant)
			begin
				block_grant <= 1'b0;
				player_grant <= 1'b0;
			end
			else if (player_req)
				player_grant <= 1'b1;
			else if (block_req)
				block_grant <= 1'b1;
		end
	end

	always_ff @(posedge clock)
	begin
		if (!reset)
		begin
			wstate <= W_IDLE;
			awvalid <= 1'b0;
			wvalid <= 1'b0;
			bready <= 1'b0;
		end
		else
		begin
			case (wstate)
				W_IDLE:
				begin
					if (owner_req)
					begin
						awvalid <= 1'b1;
						wvalid <= 1'b1;
						wstate <= W_SEND;
					end
				end
				W_SEND:
				begin
					if (awready)
						awvalid <= 1'b0;
					if (wready)
						wvalid <= 1'b0;
					if ((awready || !awvalid) && (wready || !wvalid))
					begin
						wstate <= W_RESP;
						bready <= 1'b1;
					end
				end
				W_RESP:
				begin
					if (bvalid)
					begin
						bready <= 1'b0;
						wstate <= W_IDLE;
					end
				end
				default:
					wstate <= W_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (start_write)
		begin
			awaddr <= player_grant ? player_pix_addr : block_pix_addr;
			wdata <= dodge_bus_pkg::AXI_DATA_W'(player_grant ? player_pix_colour :
				block_pix_colour);
		end
	end

	aw_stable: assert property (
		@(posedge clock) disable iff (!reset)
		awvalid && !awready |=> awvalid && $stable(awaddr));

	w_stable: assert property (
		@(posedge clock) disable iff (!reset)
		wvalid && !wready |=> wvalid && $stable(wdata));

	resp_okay: assert property (
		@(posedge clock) disable iff (!reset)
		bvalid && bready |-> bresp == dodge_bus_pkg::RESP_OKAY);

endmodule

`default_nettype wire

// File: logic/dodge_top.sv
`timescale 1ns/1ps
`default_nettype none

module dodge_top (
	input logic clock,
	input logic reset,
	input logic start,
	input logic move_left,
	input logic move_right,
	input logic move_up,
	input logic move_down,
	output logic game_over,
	output logic [dodge_bus_pkg::PIX_ADDR_W-1:0] awaddr,
	output logic awvalid,
	input logic awready,
	output logic [dodge_bus_pkg::AXI_DATA_W-1:0] wdata,
	output logic wvalid,
	input logic wready,
	input logic [dodge_bus_pkg::RESP_W-1:0] bresp,
	input logic bvalid,
	output logic bready
);

	logic advance;
	logic hit;
	logic block_paint_start;
	logic player_paint_start;
	logic block_done;
	logic player_done;
	logic [dodge_bus_pkg::COLOUR_W-1:0] paint_colour_block;
	logic [dodge_bus_pkg::COLOUR_W-1:0] paint_colour_player;
	dodge_cfg_pkg::cell_t player;
	logic [dodge_cfg_pkg::NUM_BLOCKS-1:0] live;
	dodge_cfg_pkg::cell_t [dodge_cfg_pkg::NUM_BLOCKS-1:0] cells;
	logic block_req;
	logic block_grant;
	logic block_pix_ack;
	logic [dodge_bus_pkg::PIX_ADDR_W-1:0] block_pix_addr;
	logic [dodge_bus_pkg::COLOUR_W-1:0] block_pix_colour;
	logic player_req;
	logic player_grant;
	logic player_pix_ack;
	logic [dodge_bus_pkg::PIX_ADDR_W-1:0] player_pix_addr;
	logic [dodge_bus_pkg::COLOUR_W-1:0] player_pix_colour;

	game_control control (
		.clock(clock), .reset(reset), .start(start), .hit(hit),
		.block_done(block_done), .player_done(player_done),
		.advance(advance), .game_over(game_over),
		.block_paint_start(block_paint_start), .player_paint_start(player_paint_start),
		.paint_colour_block(paint_colour_block), .paint_colour_player(paint_colour_player)
	);

	block_field field (
		.clock(clock), .reset(reset), .start(start), .advance(advance),
		.player(player), .live(live), .cells(cells), .hit(hit)
	);

	player_pos pos (
		.clock(clock), .reset(reset), .start(start), .advance(advance),
		.move_left(move_left), .move_right(move_right),
		.move_up(move_up), .move_down(move_down), .player(player)
	);

	square_painter #(.SLOTS(dodge_cfg_pkg::NUM_BLOCKS)) block_painter (
		.clock(clock), .reset(reset), .paint_start(block_paint_start),
		.paint_colour(paint_colour_block), .cells(cells), .live(live),
		.grant(block_grant), .pix_ack(block_pix_ack), .req(block_req),
		.paint_done(block_done), .pix_addr(block_pix_addr), .pix_colour(block_pix_colour)
	);

	// The player square is a single slot that is always live
	square_painter #(.SLOTS(1)) player_painter (
		.clock(clock), .reset(reset), .paint_start(player_paint_start),
		.paint_colour(paint_colour_player), .cells(player), .live(1'b1),
		.grant(player_grant), .pix_ack(player_pix_ack), .req(player_req),
		.paint_done(player_done), .pix_addr(player_pix_addr), .pix_colour(player_pix_colour)
	);

	pixel_arbiter arbiter (
		.clock(clock), .reset(reset),
		.block_req(block_req), .block_pix_addr(block_pix_addr),
		.block_pix_colour(block_pix_colour),
		.player_req(player_req), .player_pix_addr(player_pix_addr),
		.player_pix_colour(player_pix_colour),
		.block_grant(block_grant), .block_pix_ack(block_pix_ack),
		.player_grant(player_grant), .player_pix_ack(player_pix_ack),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready)
	);

endmodule

`default_nettype wire

// File: tests/dodge_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dodge_tb;

	localparam int ROWS = 16;
	// Worst case cycles for one pixel write under slave stalls
	localparam int MAX_WRITE_CYCLES = 16;

	logic clock = 1'b0;
	logic reset;
	logic start;
	logic move_left;
	logic move_right;
	logic move_up;
	logic move_down;
	logic game_over;
	logic [dodge_bus_pkg::PIX_ADDR_W-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [dodge_bus_pkg::AXI_DATA_W-1:0] wdata;
	logic wvalid;
	logic wready;
	logic [dodge_bus_pkg::RESP_W-1:0] bresp;
	logic bvalid;
	logic bready;

	// Move code 0 none, 1 left, 2 right, 3 up, 4 down
	int tbl_move[ROWS] = '{0, 2, 2, 2, 2, 2, 2, 4, 4, 1, 3, 0, 0, 3, 3, 1};
	int tbl_start[ROWS] = '{1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0};
	int tbl_steps[ROWS] = '{2, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 3, 2, 1, 1, 1};

	logic [dodge_bus_pkg::PIX_ADDR_W-1:0] aw_q[$];
	logic [dodge_bus_pkg::AXI_DATA_W-1:0] w_q[$];
	dodge_cfg_pkg::cell_t drawn[$];
	dodge_cfg_pkg::cell_t prev_blocks[$];
	dodge_cfg_pkg::cell_t cur_blocks[$];
	dodge_cfg_pkg::cell_t exp_player;
	logic aw_got;
	logic w_got;
	logic go_prev;
	logic [dodge_bus_pkg::PIX_X_W-1:0] sq_x;
	logic [dodge_bus_pkg::PIX_Y_W-1:0] sq_y;
	logic [dodge_bus_pkg::COLOUR_W-1:0] sq_colour;
	int aw_wait = 0;
	int w_wait = 0;
	int b_wait = 0;
	int pix_idx = 0;
	int pending = 0;
	int spawns = 0;
	int draws_seen = 0;
	int errors = 0;
	int cycles = 0;
	int timeout_limit = 32'h7fffffff;
	bit first_step = 1'b1;
	bit in_draw = 1'b1;

	dodge_top DUT (
		.clock(clock), .reset(reset), .start(start),
		.move_left(move_left), .move_right(move_right),
		.move_up(move_up), .move_down(move_down), .game_over(game_over),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready)
	);

	always #5 clock = ~clock;

	task automatic abort_run(input string why);
		errors++;
		$display("%s at %0t", why, $time);
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic check_addr(input string name, input logic [dodge_bus_pkg::PIX_ADDR_W-1:0] exp,
		input logic [dodge_bus_pkg::PIX_ADDR_W-1:0] got);
		if (got !== exp)
		begin
			$display("[FAIL] %0t %s expected %h got %h", $time, name, exp, got);
			abort_run("pixel address mismatch");
		end
	endtask

	task automatic check_colour(input string name, input logic [dodge_bus_pkg::AXI_DATA_W-1:0] exp,
		input logic [dodge_bus_pkg::AXI_DATA_W-1:0] got);
		if (got !== exp)
		begin
			$display("[FAIL] %0t %s expected %h got %h", $time, name, exp, got);
			abort_run("colour mismatch");
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic got);
		if (got !== exp)
		begin
			$display("[FAIL] %0t %s expected %b got %b", $time, name, exp, got);
			abort_run("flag mismatch");
		end
	endtask

	function automatic dodge_cfg_pkg::cell_t apply_move(input dodge_cfg_pkg::cell_t c, input int code);
		dodge_cfg_pkg::cell_t n;
		n = c;
		if (code == 1 && c.col != 0)
			n.col = c.col - 3'd1;
		else if (code == 2 && int'(c.col) != dodge_cfg_pkg::GRID_CELLS - 1)
			n.col = c.col + 3'd1;
		else if (code == 3 && c.row != 0)
			n.row = c.row - 3'd1;
		else if (code == 4 && int'(c.row) != dodge_cfg_pkg::GRID_CELLS - 1)
			n.row = c.row + 3'd1;
		return n;
	endfunction

	function automatic bit adjacent(input dodge_cfg_pkg::cell_t a, input dodge_cfg_pkg::cell_t b);
		int dc;
		int dr;
		dc = int'(a.col) - int'(b.col);
		dr = int'(a.row) - int'(b.row);
		return (dc * dc + dr * dr) == 1;
	endfunction

	function automatic bit on_edge(input dodge_cfg_pkg::cell_t c);
		int last;
		last = dodge_cfg_pkg::GRID_CELLS - 1;
		return c.col == 0 || c.row == 0 || int'(c.col) == last || int'(c.row) == last;
	endfunction

	function automatic logic [dodge_bus_pkg::PIX_ADDR_W-1:0] cell_addr(input dodge_cfg_pkg::cell_t c);
		int x;
		int y;
		x = dodge_cfg_pkg::ORIGIN_X + int'(c.col) * dodge_cfg_pkg::CELL_PITCH;
		y = dodge_cfg_pkg::ORIGIN_Y + int'(c.row) * dodge_cfg_pkg::CELL_PITCH;
		return {7'(y), 8'(x)};
	endfunction

	task automatic begin_draw();
		if (!first_step && drawn.size() != 0)
			abort_run("a square of the last step was not erased before drawing");
		drawn.delete();
		first_step = 1'b0;
		in_draw = 1'b1;
		exp_player = apply_move(exp_player, pending);
		pending = 0;
		prev_blocks = cur_blocks;
		cur_blocks.delete();
		spawns = 0;
	endtask

	task automatic note_block(input dodge_cfg_pkg::cell_t c);
		bit near;
		near = 1'b0;
		foreach (prev_blocks[i])
			if (adjacent(prev_blocks[i], c))
				near = 1'b1;
		if (!near)
		begin
			spawns++;
			if (spawns > 1 || !on_edge(c))
				abort_run("block square does not follow any block of the last step");
		end
		if (c == exp_player)
			abort_run("block drawn on the player cell without game over");
		cur_blocks.push_back(c);
	endtask

	task automatic confirm_game_over();
		bit near;
		near = on_edge(exp_player);
		foreach (cur_blocks[i])
			if (adjacent(cur_blocks[i], exp_player))
				near = 1'b1;
		if (!near)
			abort_run("game over without any block able to reach the player");
	endtask

	task automatic square_done();
		int dx;
		int dy;
		int found;
		dodge_cfg_pkg::cell_t c;
		dx = int'(sq_x) - dodge_cfg_pkg::ORIGIN_X;
		dy = int'(sq_y) - dodge_cfg_pkg::ORIGIN_Y;
		if (dx < 0 || dy < 0 || dx % dodge_cfg_pkg::CELL_PITCH != 0 ||
			dy % dodge_cfg_pkg::CELL_PITCH != 0 ||
			dx / dodge_cfg_pkg::CELL_PITCH >= dodge_cfg_pkg::GRID_CELLS ||
			dy / dodge_cfg_pkg::CELL_PITCH >= dodge_cfg_pkg::GRID_CELLS)
			abort_run("square origin is not on a grid cell");
		c.col = 3'(dx / dodge_cfg_pkg::CELL_PITCH);
		c.row = 3'(dy / dodge_cfg_pkg::CELL_PITCH);
		if (sq_colour == dodge_bus_pkg::COLOUR_ERASE)
		begin
			in_draw = 1'b0;
			if (!first_step)
			begin
				found = -1;
				foreach (drawn[i])
					if (found < 0 && drawn[i] == c)
						found = i;
				if (found < 0)
					abort_run("erased a square that was not drawn in the last step");
				drawn.delete(found);
			end
		end
		else
		begin
			if (!in_draw)
				begin_draw();
			drawn.push_back(c);
			if (sq_colour == dodge_bus_pkg::COLOUR_BLOCK)
				note_block(c);
			else if (sq_colour == dodge_bus_pkg::COLOUR_PLAYER)
			begin
				check_addr("player square origin", cell_addr(exp_player), {sq_y, sq_x});
				draws_seen++;
			end
			else
				abort_run("square painted in an unknown colour");
		end
	endtask

	task automatic process_pixel(input logic [dodge_bus_pkg::PIX_ADDR_W-1:0] addr,
		input logic [dodge_bus_pkg::AXI_DATA_W-1:0] data);
		logic [dodge_bus_pkg::PIX_X_W-1:0] ex;
		logic [dodge_bus_pkg::PIX_Y_W-1:0] ey;
		if (pix_idx == 0)
		begin
			sq_x = addr[dodge_bus_pkg::PIX_X_W-1:0];
			sq_y = addr[dodge_bus_pkg::PIX_ADDR_W-1:dodge_bus_pkg::PIX_X_W];
			sq_colour = data[dodge_bus_pkg::COLOUR_W-1:0];
		end
		ex = sq_x + 8'(pix_idx % dodge_cfg_pkg::SQUARE_SIZE);
		ey = sq_y + 7'(pix_idx / dodge_cfg_pkg::SQUARE_SIZE);
		check_addr("awaddr", {ey, ex}, addr);
		check_colour("wdata", dodge_bus_pkg::AXI_DATA_W'(sq_colour), data);
		if (pix_idx == dodge_cfg_pkg::SQUARE_SIZE * dodge_cfg_pkg::SQUARE_SIZE - 1)
		begin
			pix_idx = 0;
			square_done();
		end
		else
			pix_idx++;
	endtask

	// AXI4-Lite slave with random stalls on every channel
	always @(posedge clock)
	begin
		if (!reset)
		begin
			awready <= 1'b0;
			wready <= 1'b0;
			bvalid <= 1'b0;
			bresp <= dodge_bus_pkg::RESP_OKAY;
			aw_got <= 1'b0;
			w_got <= 1'b0;
		end
		else
		begin
			if ((awready && !awvalid) || (wready && !wvalid))
				abort_run("valid dropped before its ready was seen");
			if ((aw_got && awvalid) || (w_got && wvalid))
				abort_run("a second write was offered before the response");
			if (awvalid && awready)
			begin
				if (game_over)
					abort_run("write issued while the game is over");
				awready <= 1'b0;
				aw_got <= 1'b1;
				aw_q.push_back(awaddr);
				aw_wait <= $urandom % 4;
			end
			else if (awvalid && !aw_got)
			begin
				if (aw_wait == 0)
					awready <= 1'b1;
				else
					aw_wait <= aw_wait - 1;
			end
			if (wvalid && wready)
			begin
				wready <= 1'b0;
				w_got <= 1'b1;
				w_q.push_back(wdata);
				w_wait <= $urandom % 4;
			end
			else if (wvalid && !w_got)
			begin
				if (w_wait == 0)
					wready <= 1'b1;
				else
					w_wait <= w_wait - 1;
			end
			if (bvalid && bready)
			begin
				bvalid <= 1'b0;
				aw_got <= 1'b0;
				w_got <= 1'b0;
				b_wait <= $urandom % 4;
				process_pixel(aw_q.pop_front(), w_q.pop_front());
			end
			else if (aw_got && w_got && !bvalid)
			begin
				if (b_wait == 0)
				begin
					bvalid <= 1'b1;
					bresp <= dodge_bus_pkg::RESP_OKAY;
				end
				else
					b_wait <= b_wait - 1;
			end
		end
	end

	// Game over needs a block next to the player or a fresh spawn on its edge
	always @(posedge clock)
	begin
		go_prev <= game_over;
		if (reset && game_over && !go_prev)
		begin
			exp_player = apply_move(exp_player, pending);
			pending = 0;
			confirm_game_over();
		end
	end

	always @(posedge clock)
	begin
		cycles++;
		if (cycles > timeout_limit)
			abort_run("timeout, the DUT stopped making progress");
	end

	task automatic run_row(input int r);
		int target;
		repeat (4) @(posedge clock);
		if (tbl_start[r] != 0)
		begin
			start <= 1'b1;
			drawn.delete();
			cur_blocks.delete();
			first_step = 1'b1;
			in_draw = 1'b1;
			pending = 0;
			exp_player.col = 3'((dodge_cfg_pkg::GRID_CELLS - 1) / 2);
			exp_player.row = 3'((dodge_cfg_pkg::GRID_CELLS - 1) / 2);
			@(posedge clock);
			start <= 1'b0;
			repeat (3) @(posedge clock);
			check_flag("game_over", 1'b0, game_over);
		end
		else if (game_over)
			return;
		else if (tbl_move[r] != 0)
		begin
			move_left <= tbl_move[r] == 1;
			move_right <= tbl_move[r] == 2;
			move_up <= tbl_move[r] == 3;
			move_down <= tbl_move[r] == 4;
			pending = tbl_move[r];
			@(posedge clock);
			move_left <= 1'b0;
			move_right <= 1'b0;
			move_up <= 1'b0;
			move_down <= 1'b0;
		end
		target = draws_seen + tbl_steps[r];
		while (draws_seen < target && !game_over)
			@(posedge clock);
		// Writes are watched by the slave model while the game is over
		if (game_over)
			repeat (300) @(posedge clock);
	endtask

	initial
	begin
		int total;
		void'($urandom(32'hbda3));
		reset = 1'b0;
		start = 1'b0;
		move_left = 1'b0;
		move_right = 1'b0;
		move_up = 1'b0;
		move_down = 1'b0;
		awready = 1'b0;
		wready = 1'b0;
		bvalid = 1'b0;
		bresp = dodge_bus_pkg::RESP_OKAY;
		go_prev = 1'b0;
		total = 0;
		foreach (tbl_steps[i])
			total += tbl_steps[i];
		timeout_limit = total * (dodge_cfg_pkg::STEP_CYCLES + 2 * 25 * 400 * MAX_WRITE_CYCLES) +
			ROWS * 400 + 100;
		repeat (8) @(posedge clock);
		reset <= 1'b1;
		@(posedge clock);
		check_flag("game_over", 1'b0, game_over);
		for (int r = 0; r < ROWS; r++)
			run_row(r);
		repeat (20) @(posedge clock);
		if (errors == 0)
		begin
			$display("Simulation finished: PASS");
			$finish;
		end
		else
		begin
			$display("Simulation finished: FAIL");
			$fatal(1, "errors found");
		end
	end

endmodule

`default_nettype wire

// File: dodge_top.f
common/dodge_cfg_pkg.sv
common/dodge_bus_pkg.sv
game/game_control.sv
game/block_field.sv
game/player_pos.sv
logic/square_painter.sv
logic/pixel_arbiter.sv
logic/dodge_top.sv
tests/dodge_tb.sv

// File: Bender.yml
package:
  name: dodge

sources:
  - common/dodge_cfg_pkg.sv
  - common/dodge_bus_pkg.sv
  - game/game_control.sv
  - game/block_field.sv
  - game/player_pos.sv
  - logic/square_painter.sv
  - logic/pixel_arbiter.sv
  - logic/dodge_top.sv
  - target: test
    files:
      - tests/dodge_tb.sv
